//--- src/tq_pkg.sv
package tq_pkg;

        // ##########################################################################
        // Widths
        // ##########################################################################
        localparam int LANES    = 8;
        localparam int COEF_W   = 16;
        localparam int QP_W     = 6;            // Legal qp is 0..51
        localparam int SIZE_W   = 2;
        localparam int IDX_W    = 5;            // 32-row coefficient buffer
        localparam int SCALE_W  = 16;
        localparam int SHIFT_W  = 5;
        localparam int OFFSET_W = 24;
        localparam int ROW_W    = LANES * COEF_W;

        // ##########################################################################
        // Quantizer constants
        // ##########################################################################
        localparam logic [SHIFT_W-1:0] Q_SHIFT_BASE = 5'd14;   // Plus qp/6
        localparam logic [SHIFT_W-1:0] OFFSET_FRAC  = 5'd9;    // Offsets in 1/512
        localparam int                 DQ_SHIFT     = 6;

        // Indexed by qp mod 6
        localparam logic [SCALE_W-1:0] QUANT_SCALE [6] = '{
                16'd26214, 16'd23302, 16'd20560, 16'd18396, 16'd16384, 16'd14564
        };
        localparam logic [SCALE_W-1:0] DEQUANT_SCALE [6] = '{
                16'd40, 16'd45, 16'd51, 16'd57, 16'd64, 16'd72
        };

        localparam logic [OFFSET_W-1:0] OFFSET_INTRA = 24'd171;
        localparam logic [OFFSET_W-1:0] OFFSET_INTER = 24'd85;

        // Rows per block of 4, 8, 16 or 32
        function automatic logic [IDX_W:0] size_rows(input logic [SIZE_W-1:0] size);
                return 6'd4 << size;
        endfunction

        // Buffer index step of 8, 4, 2 or 1
        function automatic logic [IDX_W-1:0] size_step(input logic [SIZE_W-1:0] size);
                return 5'd8 >> size;
        endfunction

endpackage

//--- src/tq_row_dispatch.sv
`timescale 1ns/1ps

module tq_row_dispatch (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          i_pipe_en,
        input  logic                          i_valid,
        input  logic [tq_pkg::ROW_W-1:0]      i_data,
        input  logic [tq_pkg::QP_W-1:0]       i_qp,
        input  logic                          i_intra,
        input  logic                          i_inverse,
        input  logic [tq_pkg::SIZE_W-1:0]     i_size,
        output logic                          o_valid,
        output logic [tq_pkg::ROW_W-1:0]      o_data,
        output logic [tq_pkg::SCALE_W-1:0]    o_scale,
        output logic [tq_pkg::SHIFT_W-1:0]    o_shift,
        output logic [tq_pkg::OFFSET_W-1:0]   o_offset,
        output logic                          o_inverse,
        output logic [tq_pkg::SIZE_W-1:0]     o_size
);

        logic [3:0]                    qp_div;
        logic [2:0]                    qp_mod;
        logic [tq_pkg::SHIFT_W-1:0]    fwd_shift;
        logic [tq_pkg::OFFSET_W-1:0]   fwd_offset;

        // One qp decode per row shared by all lanes
        assign qp_div    = 4'(i_qp / 6'd6);
        assign qp_mod    = 3'(i_qp % 6'd6);
        assign fwd_shift = tq_pkg::Q_SHIFT_BASE + {1'b0, qp_div};

        always_comb
        begin
                if (i_intra)
                        fwd_offset = tq_pkg::OFFSET_INTRA << (fwd_shift - tq_pkg::OFFSET_FRAC);
                else
                        fwd_offset = tq_pkg::OFFSET_INTER << (fwd_shift - tq_pkg::OFFSET_FRAC);
        end

        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                begin
                        o_valid   <= 1'b0;
                        o_data    <= '0;
                        o_scale   <= '0;
                        o_shift   <= '0;
                        o_offset  <= '0;
                        o_inverse <= 1'b0;
                        o_size    <= '0;
                end
                else if (i_pipe_en)
                begin
                        o_valid   <= i_valid;
                        o_data    <= i_data;
                        o_inverse <= i_inverse;
                        o_size    <= i_size;
                        if (i_inverse)
                        begin
                                o_scale  <= tq_pkg::DEQUANT_SCALE[qp_mod];
                                o_shift  <= {1'b0, qp_div};     // Left shift for dequant
                                o_offset <= '0;
                        end
                        else
                        begin
                                o_scale  <= tq_pkg::QUANT_SCALE[qp_mod];
                                o_shift  <= fwd_shift;
                                o_offset <= fwd_offset;
                        end
                end
        end

endmodule

//--- src/tq_quant_lane.sv
`timescale 1ns/1ps

module tq_quant_lane (
        input  logic                                 clk,
        input  logic                                 rst,
        input  logic                                 i_pipe_en,
        input  logic signed [tq_pkg::COEF_W-1:0]     i_coef,
        input  logic        [tq_pkg::SCALE_W-1:0]    i_scale,
        input  logic        [tq_pkg::SHIFT_W-1:0]    i_shift,
        input  logic        [tq_pkg::OFFSET_W-1:0]   i_offset,
        input  logic                                 i_inverse,
        output logic signed [tq_pkg::COEF_W-1:0]     o_coef
);

        // ##########################################################################
        // Forward quantization
        // ##########################################################################
        logic                                                 coef_neg;
        logic signed [tq_pkg::COEF_W:0]                       coef_ext;
        logic        [tq_pkg::COEF_W:0]                       mag;
        logic        [tq_pkg::COEF_W+tq_pkg::SCALE_W+1:0]     q_sum;
        logic        [tq_pkg::COEF_W+tq_pkg::SCALE_W+1:0]     q_shr;
        logic        [tq_pkg::COEF_W-2:0]                     q_mag;
        logic signed [tq_pkg::COEF_W-1:0]                     q_res;

        assign coef_neg = i_coef[tq_pkg::COEF_W-1];
        assign coef_ext = {i_coef[tq_pkg::COEF_W-1], i_coef};
        assign mag      = coef_neg ? -coef_ext : coef_ext;     // 17 bits so -32768 fits

        always_comb
        begin
                q_sum = mag * i_scale + i_offset;
                q_shr = q_sum >> i_shift;
                if (|q_shr[tq_pkg::COEF_W+tq_pkg::SCALE_W+1:tq_pkg::COEF_W-1])
                        q_mag = '1;                             // Saturate at 32767
                else
                        q_mag = q_shr[tq_pkg::COEF_W-2:0];
                q_res = coef_neg ? -$signed({1'b0, q_mag}) : $signed({1'b0, q_mag});
        end

        // ##########################################################################
        // Dequantization
        // ##########################################################################
        logic signed [2*tq_pkg::COEF_W+tq_pkg::SCALE_W-1:0]   dq_acc;
        logic signed [2*tq_pkg::COEF_W+tq_pkg::SCALE_W-1:0]   dq_rnd;
        logic signed [tq_pkg::COEF_W-1:0]                     dq_res;

        always_comb
        begin
                dq_acc = (i_coef * $signed({1'b0, i_scale})) <<< i_shift;
                dq_rnd = (dq_acc + (1 <<< (tq_pkg::DQ_SHIFT - 1))) >>> tq_pkg::DQ_SHIFT;
                if (dq_rnd > 32767)
                        dq_res = 16'sh7fff;
                else if (dq_rnd < -32768)
                        dq_res = -16'sh8000;
                else
                        dq_res = dq_rnd[tq_pkg::COEF_W-1:0];
        end

        // Stage 2 register
        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                        o_coef <= '0;
                else if (i_pipe_en)
                        o_coef <= i_inverse ? dq_res : q_res;
        end

endmodule

//--- src/tq_row_collect.sv
`timescale 1ns/1ps

module tq_row_collect (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          i_ready,
        input  logic                          i_valid,
        input  logic [tq_pkg::SIZE_W-1:0]     i_size,
        input  logic [tq_pkg::ROW_W-1:0]      i_data,
        output logic                          o_pipe_en,
        output logic                          o_valid,
        output logic [tq_pkg::ROW_W-1:0]      o_data,
        output logic [tq_pkg::IDX_W-1:0]      o_idx,
        output logic                          o_last
);

        logic                          s2_valid;
        logic [tq_pkg::SIZE_W-1:0]     s2_size;
        logic [tq_pkg::IDX_W-1:0]      row_cnt;        // Row within current block
        logic [tq_pkg::IDX_W-1:0]      row_idx;
        logic                          row_last;

        // Whole pipe moves only when the output slot frees up
        assign o_pipe_en = !o_valid || i_ready;

        assign row_idx  = row_cnt * tq_pkg::size_step(s2_size);
        assign row_last = ({1'b0, row_cnt} == tq_pkg::size_rows(s2_size) - 1'b1);

        // ##########################################################################
        // Stage 2 control in step with the lane registers
        // ##########################################################################
        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                begin
                        s2_valid <= 1'b0;
                        s2_size  <= '0;
                end
                else if (o_pipe_en)
                begin
                        s2_valid <= i_valid;
                        s2_size  <= i_size;
                end
        end

        // ##########################################################################
        // Output register and block row counter
        // ##########################################################################
        always_ff @(posedge clk or negedge rst)
        begin
                if (!rst)
                begin
                        o_valid <= 1'b0;
                        o_data  <= '0;
                        o_idx   <= '0;
                        o_last  <= 1'b0;
                        row_cnt <= '0;
                end
                else if (o_pipe_en)
                begin
                        o_valid <= s2_valid;
                        o_last  <= s2_valid && row_last;
                        if (s2_valid)
                        begin
                                o_data <= i_data;
                                o_idx  <= row_idx;
                                if (row_last)
                                        row_cnt <= '0;          // Block done
                                else
                                        row_cnt <= row_cnt + 1'b1;
                        end
                end
        end

endmodule

//--- src/tq_quant_top.sv
`timescale 1ns/1ps

module tq_quant_top (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          i_valid,
        input  logic [tq_pkg::ROW_W-1:0]      i_data,
        input  logic [tq_pkg::QP_W-1:0]       i_qp,
        input  logic                          i_intra,
        input  logic                          i_inverse,
        input  logic [tq_pkg::SIZE_W-1:0]     i_size,
        input  logic                          i_ready,
        output logic                          o_ready,
        output logic                          o_valid,
        output logic [tq_pkg::ROW_W-1:0]      o_data,
        output logic [tq_pkg::IDX_W-1:0]      o_idx,
        output logic                          o_last
);

        logic                          pipe_en;
        logic                          s1_valid;
        logic [tq_pkg::ROW_W-1:0]      s1_data;
        logic [tq_pkg::SCALE_W-1:0]    s1_scale;
        logic [tq_pkg::SHIFT_W-1:0]    s1_shift;
        logic [tq_pkg::OFFSET_W-1:0]   s1_offset;
        logic                          s1_inverse;
        logic [tq_pkg::SIZE_W-1:0]     s1_size;
        logic [tq_pkg::ROW_W-1:0]      s2_data;

        assign o_ready = pipe_en;

        tq_row_dispatch tq_row_dispatch_inst (
                .clk       (clk),
                .rst       (rst),
                .i_pipe_en (pipe_en),
                .i_valid   (i_valid),
                .i_data    (i_data),
                .i_qp      (i_qp),
                .i_intra   (i_intra),
                .i_inverse (i_inverse),
                .i_size    (i_size),
                .o_valid   (s1_valid),
                .o_data    (s1_data),
                .o_scale   (s1_scale),
                .o_shift   (s1_shift),
                .o_offset  (s1_offset),
                .o_inverse (s1_inverse),
                .o_size    (s1_size)
        );

        // One lane per coefficient
        for (genvar g = 0; g < tq_pkg::LANES; g++)
        begin : g_lane
                tq_quant_lane tq_quant_lane_inst (
                        .clk       (clk),
                        .rst       (rst),
                        .i_pipe_en (pipe_en),
                        .i_coef    (s1_data[g*tq_pkg::COEF_W +: tq_pkg::COEF_W]),
                        .i_scale   (s1_scale),
                        .i_shift   (s1_shift),
                        .i_offset  (s1_offset),
                        .i_inverse (s1_inverse),
                        .o_coef    (s2_data[g*tq_pkg::COEF_W +: tq_pkg::COEF_W])
                );
        end

        tq_row_collect tq_row_collect_inst (
                .clk       (clk),
                .rst       (rst),
                .i_ready   (i_ready),
                .i_valid   (s1_valid),
                .i_size    (s1_size),
                .i_data    (s2_data),
                .o_pipe_en (pipe_en),
                .o_valid   (o_valid),
                .o_data    (o_data),
                .o_idx     (o_idx),
                .o_last    (o_last)
        );

endmodule

//--- testbench/tq_ref_model.svh
`ifndef TQ_REF_MODEL_SVH
`define TQ_REF_MODEL_SVH

// Forward quantization of one coefficient to a level
function automatic logic [15:0] quant_model(input logic signed [15:0] coef, input int qp,
                                            input logic intra);
        longint mag;
        longint shift;
        longint offset;
        longint lvl;
        mag    = (coef < 0) ? -longint'(coef) : longint'(coef);
        shift  = longint'(tq_pkg::Q_SHIFT_BASE) + qp / 6;
        offset = intra ? longint'(tq_pkg::OFFSET_INTRA) : longint'(tq_pkg::OFFSET_INTER);
        offset = offset << (shift - 9);                 // Offset given in 1/512
        lvl    = (mag * longint'(tq_pkg::QUANT_SCALE[qp % 6]) + offset) >> shift;
        if (lvl > 32767)
                lvl = 32767;
        return (coef < 0) ? 16'(-lvl) : 16'(lvl);
endfunction

// Level back to a coefficient, clipped to 16 bits signed
function automatic logic [15:0] dequant_model(input logic signed [15:0] lvl, input int qp);
        longint acc;
        acc = longint'(lvl) * longint'(tq_pkg::DEQUANT_SCALE[qp % 6]);
        acc = acc << (qp / 6);
        acc = (acc + 32) >>> tq_pkg::DQ_SHIFT;
        if (acc > 32767)
                acc = 32767;
        else if (acc < -32768)
                acc = -32768;
        return 16'(acc);
endfunction

function automatic logic [tq_pkg::ROW_W-1:0] row_model(input logic [tq_pkg::ROW_W-1:0] data,
                                                       input int qp, input logic intra,
                                                       input logic inverse);
        logic [tq_pkg::ROW_W-1:0] res;
        for (int i = 0; i < tq_pkg::LANES; i++)
        begin
                if (inverse)
                        res[i*tq_pkg::COEF_W +: tq_pkg::COEF_W] =
                                dequant_model(data[i*tq_pkg::COEF_W +: tq_pkg::COEF_W], qp);
                else
                        res[i*tq_pkg::COEF_W +: tq_pkg::COEF_W] =
                                quant_model(data[i*tq_pkg::COEF_W +: tq_pkg::COEF_W], qp, intra);
        end
        return res;
endfunction

// Rows per block and buffer index step for a size code
function automatic int block_rows(input logic [1:0] size);
        return 4 << size;
endfunction

function automatic int row_step(input logic [1:0] size);
        return 8 >> size;
endfunction

`endif

//--- testbench/tb_tq_quant_top.sv
`timescale 1ns/1ps

module tb_tq_quant_top;

        localparam int TOTAL_ROWS = 168;

        logic                           clk;
        logic                           rst;
        logic                           i_valid;
        logic [tq_pkg::ROW_W-1:0]       i_data;
        logic [tq_pkg::QP_W-1:0]        i_qp;
        logic                           i_intra;
        logic                           i_inverse;
        logic [tq_pkg::SIZE_W-1:0]      i_size;
        logic                           i_ready;
        logic                           o_ready;
        logic                           o_valid;
        logic [tq_pkg::ROW_W-1:0]       o_data;
        logic [tq_pkg::IDX_W-1:0]       o_idx;
        logic                           o_last;

        logic [15:0]                    lfsr_state = 16'd42001;
        logic [tq_pkg::ROW_W-1:0]       exp_data [$];
        logic [tq_pkg::IDX_W-1:0]       exp_idx [$];
        logic                           exp_last [$];
        int                             exp_cycle [$];
        logic [tq_pkg::ROW_W-1:0]       saved_data [$];
        int                             saved_qp [$];
        string                          test_name = "reset";
        int                             cycle = 0;
        int                             block_cnt = 0;      // Model's row within block
        int                             errors = 0;
        int                             checks = 0;
        int                             rows_in = 0;
        int                             rows_out = 0;
        int                             err_start = 0;
        int                             in_start = 0;
        int                             out_start = 0;
        bit                             check_latency = 1'b1;
        bit                             ready_random = 1'b0;
        bit                             hold_pending = 1'b0;
        logic [tq_pkg::ROW_W+tq_pkg::IDX_W+1:0] hold_row;

        `include "tq_ref_model.svh"

        tq_quant_top tq_quant_top_inst (.*);

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // ##########################################################################
        // Random source with feedback taps 16, 14, 13 and 11
        // ##########################################################################
        function automatic logic [15:0] lfsr_next(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int k = 0; k < n; k++)
                begin
                        lfsr_state = lfsr_next(lfsr_state);
                        r = {r[30:0], lfsr_state[0]};
                end
                return r;
        endfunction

        function automatic logic [tq_pkg::ROW_W-1:0] rand_coefs();
                logic [tq_pkg::ROW_W-1:0] r;
                for (int i = 0; i < tq_pkg::LANES; i++)
                        r[i*16 +: 16] = 16'(rand_bits(16));
                return r;
        endfunction

        function automatic logic [tq_pkg::ROW_W-1:0] rand_levels();
                logic [tq_pkg::ROW_W-1:0] r;
                logic [15:0]              v;
                for (int i = 0; i < tq_pkg::LANES; i++)
                begin
                        v = 16'(rand_bits(16));
                        case (rand_bits(2))
                                0: v = 16'h7fff - {12'd0, v[3:0]};      // Near full scale
                                1: v = 16'h8000 + {12'd0, v[3:0]};
                                2: v = {{8{v[7]}}, v[7:0]};
                                default: ;
                        endcase
                        r[i*16 +: 16] = v;
                end
                return r;
        endfunction

        task automatic check_value(input string name, input logic [159:0] expected,
                                   input logic [159:0] actual);
                checks++;
                if (expected !== actual)
                begin
                        errors++;
                        $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
                end
        endtask

        // ##########################################################################
        // Source, sink and scoreboard
        // ##########################################################################
        task automatic send_row(input logic [tq_pkg::ROW_W-1:0] data, input int qp,
                                input logic intra, input logic inverse, input logic [1:0] size);
                i_valid   = 1'b1;
                i_data    = data;
                i_qp      = 6'(qp);
                i_intra   = intra;
                i_inverse = inverse;
                i_size    = size;
                @(negedge clk);
                while (!o_ready)
                        @(negedge clk);
                @(posedge clk);
                #1;
                i_valid = 1'b0;
        endtask

        task automatic send_mixed_block(input logic [1:0] size);
                logic                     inverse;
                logic                     intra;
                logic [tq_pkg::ROW_W-1:0] d;
                int                       qp;
                for (int r = 0; r < block_rows(size); r++)
                begin
                        inverse = rand_bits(1);
                        intra   = rand_bits(1);
                        qp      = rand_bits(6) % 52;
                        d       = inverse ? rand_levels() : rand_coefs();
                        send_row(d, qp, intra, inverse, size);
                end
        endtask

        // Next i_ready is chosen at the falling edge, driven after the rising one
        initial
        begin
                logic r;
                forever
                begin
                        @(negedge clk);
                        r = ready_random ? rand_bits(1) : 1'b1;
                        @(posedge clk);
                        #1;
                        i_ready = r;
                end
        end

        always @(negedge clk)
        begin
                cycle++;
                if (hold_pending)
                        check_value({test_name, " stall hold"}, hold_row,
                                    {o_valid, o_data, o_idx, o_last});
                hold_pending = o_valid && !i_ready;
                hold_row     = {o_valid, o_data, o_idx, o_last};
                if (o_valid && i_ready)
                begin
                        rows_out++;
                        if (exp_data.size() == 0)
                        begin
                                errors++;
                                $display("Error in %s: output row with no row expected", test_name);
                        end
                        else
                        begin
                                check_value({test_name, " o_data"}, exp_data.pop_front(), o_data);
                                check_value({test_name, " o_idx"}, exp_idx.pop_front(), o_idx);
                                check_value({test_name, " o_last"}, exp_last.pop_front(), o_last);
                                if (check_latency)
                                        check_value({test_name, " latency"}, 3,
                                                    cycle - exp_cycle[0]);
                                void'(exp_cycle.pop_front());
                        end
                end
                if (i_valid && o_ready)
                begin
                        exp_data.push_back(row_model(i_data, i_qp, i_intra, i_inverse));
                        exp_idx.push_back(5'(block_cnt * row_step(i_size)));
                        exp_last.push_back(block_cnt == block_rows(i_size) - 1);
                        exp_cycle.push_back(cycle);
                        block_cnt = (block_cnt == block_rows(i_size) - 1) ? 0 : block_cnt + 1;
                        rows_in++;
                end
        end

        task automatic end_test();
                int wait_cycles;
                wait_cycles = 0;
                while (exp_data.size() != 0 && wait_cycles < 200)
                begin
                        @(negedge clk);
                        wait_cycles++;
                end
                if (exp_data.size() != 0)
                begin
                        errors++;
                        $display("Error in %s: %0d rows never came out", test_name,
                                 exp_data.size());
                end
                check_value({test_name, " row count"}, rows_in - in_start, rows_out - out_start);
                @(posedge clk);
                #1;
                $display("Test %s done: %0d rows, %0d errors", test_name, rows_out - out_start,
                         errors - err_start);
                err_start = errors;
                in_start  = rows_in;
                out_start = rows_out;
        endtask

        initial
        begin
                repeat (TOTAL_ROWS * 20) @(posedge clk);
                $display("Error: timeout after %0d cycles, rows stopped moving", TOTAL_ROWS * 20);
                $display("Finished with errors");
                $finish;
        end

        // ##########################################################################
        // Tests
        // ##########################################################################
        initial
        begin
                logic [tq_pkg::ROW_W-1:0] d;
                int                       qp;
                rst       = 1'b0;
                i_valid   = 1'b0;
                i_data    = '0;
                i_qp      = '0;
                i_intra   = 1'b0;
                i_inverse = 1'b0;
                i_size    = '0;
                i_ready   = 1'b1;
                repeat (3)
                begin
                        @(negedge clk);
                        check_value("reset outputs", 8'b0000_0001,
                                    {o_valid, o_last, o_idx, o_ready});
                end
                @(posedge clk);
                #1;
                rst = 1'b1;
                @(negedge clk);
                check_value("reset release", 8'b0000_0001, {o_valid, o_last, o_idx, o_ready});
                @(posedge clk);
                #1;
                end_test();

                test_name = "forward_intra";
                for (int r = 0; r < 16; r++)
                begin
                        d  = rand_coefs();
                        qp = rand_bits(6) % 52;
                        saved_data.push_back(d);
                        saved_qp.push_back(qp);
                        send_row(d, qp, 1'b1, 1'b0, 2'd1);
                end
                end_test();

                test_name = "forward_inter";        // Same rows again
                for (int r = 0; r < 16; r++)
                        send_row(saved_data[r], saved_qp[r], 1'b0, 1'b0, 2'd1);
                end_test();

                test_name = "inverse";
                for (int r = 0; r < 16; r++)
                begin
                        d  = rand_levels();
                        qp = rand_bits(6) % 52;
                        send_row(d, qp, 1'b0, 1'b1, 2'd1);
                end
                end_test();

                test_name = "indexing";
                for (int s = 0; s < 4; s++)
                        send_mixed_block(2'(s));
                end_test();

                test_name     = "back_pressure";
                check_latency = 1'b0;
                ready_random  = 1'b1;
                for (int s = 3; s >= 0; s--)
                        send_mixed_block(2'(s));
                end_test();
                ready_random = 1'b0;

                $display("Checks %0d, errors %0d, rows in %0d, rows out %0d",
                         checks, errors, rows_in, rows_out);
                if (errors == 0)
                        $display("Finished with no errors");
                else
                        $display("Finished with errors");
                $finish;
        end

endmodule

//--- flist.f
+incdir+testbench
src/tq_pkg.sv
src/tq_row_dispatch.sv
src/tq_quant_lane.sv
src/tq_row_collect.sv
src/tq_quant_top.sv
testbench/tb_tq_quant_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        --top-module tb_tq_quant_top -f flist.f -o tb_tq_quant_top

./obj_dir/tb_tq_quant_top | tee sim.log

if grep -q "Finished with errors" sim.log
then
        echo "Simulation FAILED"
        exit 1
fi
echo "Simulation PASSED"
